/* filelist.f */
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/rename_map_table.sv
hdl/rename_merge.sv
hdl/rename_stage.sv
tb/rename_tb.sv

/* hdl/free_list.sv */
module free_list (
    input  logic                          clk,
    input  logic                          reset,

    // Pop from the tail
    input  logic                          dequeue_en,
    output logic [rename_pkg::PR_IDX_W-1:0] dequeue_pr,
    output logic                          was_dequeued,

    // Push at the head
    input  logic                          enqueue_en,
    input  logic [rename_pkg::PR_IDX_W-1:0] enqueue_pr,
    output logic                          was_enqueued,

    output logic                          is_empty,
    output logic                          is_full
);

    import rename_pkg::*;

    // Circular queue of free PR numbers
    logic [PR_IDX_W-1:0] slots [FREE_LIST_SIZE];

    // Head is the next slot to fill, tail the oldest filled slot
    logic [FL_PTR_W-1:0] head_ptr;
    logic [FL_PTR_W-1:0] tail_ptr;

    // Pointer advance, wraps at FREE_LIST_SIZE
    function automatic logic [FL_PTR_W-1:0] ptr_next(input logic [FL_PTR_W-1:0] p);
        if (p == FL_PTR_W'(FREE_LIST_SIZE - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign is_empty = (head_ptr == tail_ptr);
    assign is_full  = (ptr_next(head_ptr) == tail_ptr);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Load PRs ARCH_REGS .. PHYS_REGS-1 in order, queue starts full
            for (int i = 0; i < FREE_LIST_SIZE; i++) begin
                slots[i] <= (i < FL_INIT_COUNT) ? PR_IDX_W'(ARCH_REGS + i) : '0;
            end
            head_ptr     <= FL_PTR_W'(FL_INIT_COUNT);
            tail_ptr     <= '0;
            dequeue_pr   <= '0;
            was_dequeued <= 1'b0;
            was_enqueued <= 1'b0;
        end else if (dequeue_en && enqueue_en && is_empty) begin
            // Empty with pop and push together
            // pushed PR goes straight out, pointers stay put
            dequeue_pr   <= enqueue_pr;
            was_dequeued <= 1'b1;
            was_enqueued <= 1'b1;
        end else begin
            // Pop side
            if (dequeue_en && !is_empty) begin
                dequeue_pr   <= slots[tail_ptr];
                tail_ptr     <= ptr_next(tail_ptr);
                was_dequeued <= 1'b1;
            end else begin
                // Idle or pop on empty, rename will stall
                dequeue_pr   <= '0;
                was_dequeued <= 1'b0;
            end

            // Push side, refused only when full and nothing leaves
            if (enqueue_en && !(is_full && !dequeue_en)) begin
                slots[head_ptr] <= enqueue_pr;
                head_ptr        <= ptr_next(head_ptr);
                was_enqueued    <= 1'b1;
            end else begin
                was_enqueued    <= 1'b0;
            end
        end
    end

    // A push into a full queue with no pop must be refused
    a_full_push_refused: assert property (
        @(posedge clk) disable iff (reset)
        (enqueue_en && is_full && !dequeue_en) |=> !was_enqueued
    );

    // After a push with no pop the queue holds at least one entry
    a_push_not_empty: assert property (
        @(posedge clk) disable iff (reset)
        (was_enqueued && !was_dequeued) |-> (head_ptr != tail_ptr)
    );

endmodule

/* hdl/rename_map_table.sv */
module rename_map_table (
    input  logic                            clk,
    input  logic                            reset,

    // Read addresses, sampled every cycle
    input  logic [rename_pkg::AR_IDX_W-1:0] src1_ar,
    input  logic [rename_pkg::AR_IDX_W-1:0] src2_ar,
    input  logic [rename_pkg::AR_IDX_W-1:0] dest_ar,

    // New mapping from the merge block
    input  logic                            map_wr_en,
    input  logic [rename_pkg::AR_IDX_W-1:0] map_wr_ar,
    input  logic [rename_pkg::PR_IDX_W-1:0] map_wr_pr,

    // Registered read data, one cycle after the addresses
    output logic [rename_pkg::PR_IDX_W-1:0] src1_pr,
    output logic [rename_pkg::PR_IDX_W-1:0] src2_pr,
    output logic [rename_pkg::PR_IDX_W-1:0] old_pr
);

    import rename_pkg::*;

    // One PR per architectural register
    logic [PR_IDX_W-1:0] map [ARCH_REGS];

    // Current mapping with the write of this cycle folded in
    function automatic logic [PR_IDX_W-1:0] lookup(input logic [AR_IDX_W-1:0] ar);
        if (map_wr_en && (map_wr_ar == ar)) begin
            return map_wr_pr;
        end
        return map[ar];
    endfunction

    // Mapping update
    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity mapping, r -> PR r
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= PR_IDX_W'(i);
            end
        end else if (map_wr_en) begin
            map[map_wr_ar] <= map_wr_pr;
        end
    end

    // Read registers
    // a rename one cycle behind sees the previous rename's PR here
    always_ff @(posedge clk) begin
        src1_pr <= lookup(src1_ar);
        src2_pr <= lookup(src2_ar);
        old_pr  <= lookup(dest_ar);
    end

    // Writes only ever carry a PR that exists
    a_wr_pr_range: assert property (
        @(posedge clk) disable iff (reset)
        map_wr_en |-> (int'(map_wr_pr) < PHYS_REGS)
    );

endmodule

/* hdl/rename_merge.sv */
module rename_merge (
    input  logic                            clk,
    input  logic                            reset,

    // Request side, same cycle as the free list pop
    input  logic                            rename_en,
    input  logic [rename_pkg::AR_IDX_W-1:0] dest_ar,

    // Registered results from the free list and map table
    input  logic [rename_pkg::PR_IDX_W-1:0] dequeue_pr,
    input  logic                            was_dequeued,
    input  logic [rename_pkg::PR_IDX_W-1:0] old_pr_in,

    // Rename result
    output rename_pkg::rename_status_e      ren_status,
    output logic [rename_pkg::PR_IDX_W-1:0] ren_dest_pr,
    output logic [rename_pkg::PR_IDX_W-1:0] ren_old_pr,

    // Map table write port
    output logic                            map_wr_en,
    output logic [rename_pkg::AR_IDX_W-1:0] map_wr_ar,
    output logic [rename_pkg::PR_IDX_W-1:0] map_wr_pr
);

    import rename_pkg::*;

    // Request delayed to meet the one-cycle-late results
    logic                rename_q;
    logic [AR_IDX_W-1:0] dest_ar_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rename_q <= 1'b0;
        end else begin
            rename_q <= rename_en;
        end
    end

    // Destination index lined up with rename_q
    always_ff @(posedge clk) begin
        dest_ar_q <= dest_ar;
    end

    // Status from the delayed request and the pop outcome
    always_comb begin
        if (!rename_q) begin
            ren_status = REN_NONE;
        end else if (was_dequeued) begin
            ren_status = REN_DONE;
        end else begin
            ren_status = REN_STALL;
        end
    end

    // Popped PR becomes the destination's new mapping
    assign ren_dest_pr = dequeue_pr;
    assign ren_old_pr  = old_pr_in;

    // Map write only on a successful rename
    assign map_wr_en = rename_q && was_dequeued;
    assign map_wr_ar = dest_ar_q;
    assign map_wr_pr = dequeue_pr;

    // Free list pops only for a registered request
    // so REN_DONE and the map write never lack one
    a_done_has_request: assert property (
        @(posedge clk) disable iff (reset)
        was_dequeued |-> rename_q
    );

endmodule

/* hdl/rename_pkg.sv */
package rename_pkg;

    // Architectural register file as seen by software
    localparam int ARCH_REGS = 32;

    // Physical register file behind the rename map
    localparam int PHYS_REGS = 48;

    // Index widths
    localparam int AR_IDX_W = $clog2(ARCH_REGS);
    localparam int PR_IDX_W = $clog2(PHYS_REGS);

    // One slot always stays empty to tell full from empty,
    // so the usable capacity is PHYS_REGS - ARCH_REGS
    localparam int FREE_LIST_SIZE = PHYS_REGS - ARCH_REGS + 1;

    // Head and tail pointers wrap modulo FREE_LIST_SIZE
    localparam int FL_PTR_W = $clog2(FREE_LIST_SIZE);

    // Number of PRs sitting in the free list after reset
    localparam int FL_INIT_COUNT = PHYS_REGS - ARCH_REGS;

    // Result of a rename, reported one cycle after the request
    typedef enum logic [1:0] {
        // No request in the previous cycle
        REN_NONE  = 2'd0,
        // Destination got a fresh PR
        REN_DONE  = 2'd1,
        // No PR was free, request dropped
        REN_STALL = 2'd2
    } rename_status_e;

endpackage

/* hdl/rename_stage.sv */
module rename_stage (
    input  logic                            clk,
    input  logic                            reset,

    // Rename request
    input  logic                            rename_en,
    input  logic [rename_pkg::AR_IDX_W-1:0] dest_ar,
    input  logic [rename_pkg::AR_IDX_W-1:0] src1_ar,
    input  logic [rename_pkg::AR_IDX_W-1:0] src2_ar,

    // Commit side, PR returned to the free list
    input  logic                            free_en,
    input  logic [rename_pkg::PR_IDX_W-1:0] free_pr,

    // Results, one cycle after the request
    output rename_pkg::rename_status_e      ren_status,
    output logic [rename_pkg::PR_IDX_W-1:0] ren_dest_pr,
    output logic [rename_pkg::PR_IDX_W-1:0] ren_old_pr,
    output logic [rename_pkg::PR_IDX_W-1:0] ren_src1_pr,
    output logic [rename_pkg::PR_IDX_W-1:0] ren_src2_pr,
    output logic                            free_accepted
);

    import rename_pkg::*;

    // Free list to merge
    logic [PR_IDX_W-1:0] dequeue_pr;
    logic                was_dequeued;

    // Map table to merge
    logic [PR_IDX_W-1:0] old_pr;

    // Merge back into the map table
    logic                map_wr_en;
    logic [AR_IDX_W-1:0] map_wr_ar;
    logic [PR_IDX_W-1:0] map_wr_pr;

    // Occupancy flags not needed at this level
    free_list free_list0 (
        .clk          (clk),
        .reset        (reset),
        .dequeue_en   (rename_en),
        .dequeue_pr   (dequeue_pr),
        .was_dequeued (was_dequeued),
        .enqueue_en   (free_en),
        .enqueue_pr   (free_pr),
        .was_enqueued (free_accepted),
        .is_empty     (),
        .is_full      ()
    );

    rename_map_table map_table0 (
        .clk       (clk),
        .reset     (reset),
        .src1_ar   (src1_ar),
        .src2_ar   (src2_ar),
        .dest_ar   (dest_ar),
        .map_wr_en (map_wr_en),
        .map_wr_ar (map_wr_ar),
        .map_wr_pr (map_wr_pr),
        .src1_pr   (ren_src1_pr),
        .src2_pr   (ren_src2_pr),
        .old_pr    (old_pr)
    );

    rename_merge merge0 (
        .clk          (clk),
        .reset        (reset),
        .rename_en    (rename_en),
        .dest_ar      (dest_ar),
        .dequeue_pr   (dequeue_pr),
        .was_dequeued (was_dequeued),
        .old_pr_in    (old_pr),
        .ren_status   (ren_status),
        .ren_dest_pr  (ren_dest_pr),
        .ren_old_pr   (ren_old_pr),
        .map_wr_en    (map_wr_en),
        .map_wr_ar    (map_wr_ar),
        .map_wr_pr    (map_wr_pr)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module rename_tb \
    --Mdir obj_dir \
    -f filelist.f \
    && ./obj_dir/Vrename_tb \
    && echo "Simulation finished with status 0" \
    || { echo "Simulation or build ended with an error"; exit 1; }

/* tb/rename_tb.sv */
module rename_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rename_pkg::*;

    // Six hex fields per stimulus line
    localparam int FIELDS    = 6;
    localparam int MAX_LINES = 64;

    logic clk = 1'b0;
    logic reset;

    // DUT inputs
    logic                rename_en;
    logic [AR_IDX_W-1:0] dest_ar;
    logic [AR_IDX_W-1:0] src1_ar;
    logic [AR_IDX_W-1:0] src2_ar;
    logic                free_en;
    logic [PR_IDX_W-1:0] free_pr;

    // DUT outputs
    rename_status_e      ren_status;
    logic [PR_IDX_W-1:0] ren_dest_pr;
    logic [PR_IDX_W-1:0] ren_old_pr;
    logic [PR_IDX_W-1:0] ren_src1_pr;
    logic [PR_IDX_W-1:0] ren_src2_pr;
    logic                free_accepted;

    // Raw stimulus, 8'hff in the first field marks the end
    logic [7:0] stim [MAX_LINES*FIELDS];
    int n_lines;
    int timeout_limit = 0;
    int cycle_count = 0;

    // Reference model state
    logic [PR_IDX_W-1:0] ref_free [$];
    logic [PR_IDX_W-1:0] ref_map [ARCH_REGS];

    // Expected results of the line in flight
    rename_status_e      exp_status;
    logic [PR_IDX_W-1:0] exp_dest_pr;
    logic [PR_IDX_W-1:0] exp_old_pr;
    logic [PR_IDX_W-1:0] exp_src1_pr;
    logic [PR_IDX_W-1:0] exp_src2_pr;
    logic                exp_accept;

    rename_stage dut0 (
        .clk           (clk),
        .reset         (reset),
        .rename_en     (rename_en),
        .dest_ar       (dest_ar),
        .src1_ar       (src1_ar),
        .src2_ar       (src2_ar),
        .free_en       (free_en),
        .free_pr       (free_pr),
        .ren_status    (ren_status),
        .ren_dest_pr   (ren_dest_pr),
        .ren_old_pr    (ren_old_pr),
        .ren_src1_pr   (ren_src1_pr),
        .ren_src2_pr   (ren_src2_pr),
        .free_accepted (free_accepted)
    );

    always #5 clk = ~clk;

    // Run limit from the stimulus length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, stimulus did not finish", cycle_count);
            $display("Regression failed");
            $fatal(1);
        end
    end

    task automatic check_status(input string test_name, input rename_status_e expected,
                                input rename_status_e actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %s actual %s", test_name, expected.name(),
                     actual.name());
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_pr(input string test_name, input logic [PR_IDX_W-1:0] expected,
                            input logic [PR_IDX_W-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %0d actual %0d", test_name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string test_name, input logic expected,
                              input logic actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %b actual %b", test_name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // One cycle of the free list and map rules
    task automatic step_model();
        logic                was_empty;
        logic                was_full;
        logic                forward;
        logic                got_pr;
        logic [PR_IDX_W-1:0] new_pr;
        // Occupancy before the cycle
        was_empty = (ref_free.size() == 0);
        was_full  = (ref_free.size() == FL_INIT_COUNT);
        forward   = rename_en && free_en && was_empty;
        exp_accept = free_en && !(was_full && !rename_en);
        got_pr = 1'b0;
        new_pr = '0;
        if (forward) begin
            new_pr = free_pr;
            got_pr = 1'b1;
        end else if (rename_en && !was_empty) begin
            new_pr = ref_free.pop_front();
            got_pr = 1'b1;
        end
        // Forwarded PR never lands in the queue
        if (exp_accept && !forward) begin
            ref_free.push_back(free_pr);
        end
        // Reads see every earlier rename
        exp_src1_pr = ref_map[src1_ar];
        exp_src2_pr = ref_map[src2_ar];
        exp_old_pr  = ref_map[dest_ar];
        exp_dest_pr = new_pr;
        if (!rename_en) begin
            exp_status = REN_NONE;
        end else if (got_pr) begin
            exp_status = REN_DONE;
            ref_map[dest_ar] = new_pr;
        end else begin
            exp_status = REN_STALL;
        end
    endtask

    // Put line n on the DUT inputs and advance the model
    task automatic drive_line(input int n);
        int k;
        k = n * FIELDS;
        rename_en = stim[k][0];
        dest_ar   = stim[k+1][AR_IDX_W-1:0];
        src1_ar   = stim[k+2][AR_IDX_W-1:0];
        src2_ar   = stim[k+3][AR_IDX_W-1:0];
        free_en   = stim[k+4][0];
        free_pr   = stim[k+5][PR_IDX_W-1:0];
        step_model();
    endtask

    task automatic check_line(input int n);
        check_status($sformatf("line %0d ren_status", n), exp_status, ren_status);
        // Dest PR only means something on a completed rename
        if (exp_status == REN_DONE) begin
            check_pr($sformatf("line %0d ren_dest_pr", n), exp_dest_pr, ren_dest_pr);
        end
        check_pr($sformatf("line %0d ren_old_pr", n), exp_old_pr, ren_old_pr);
        check_pr($sformatf("line %0d ren_src1_pr", n), exp_src1_pr, ren_src1_pr);
        check_pr($sformatf("line %0d ren_src2_pr", n), exp_src2_pr, ren_src2_pr);
        check_flag($sformatf("line %0d free_accepted", n), exp_accept, free_accepted);
    endtask

    initial begin
        reset     = 1'b1;
        rename_en = 1'b0;
        dest_ar   = '0;
        src1_ar   = '0;
        src2_ar   = '0;
        free_en   = 1'b0;
        free_pr   = '0;

        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            stim[i] = 8'hff;
        end
        $readmemh("tb/rename_testdata.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && stim[n_lines*FIELDS] != 8'hff) begin
            n_lines++;
        end
        timeout_limit = n_lines + 20;
        if (n_lines == 0) begin
            $display("No stimulus lines found in the data file");
            $display("Regression failed");
            $fatal(1);
        end

        // Model after reset, PRs 32..47 free and identity map
        for (int i = 0; i < FL_INIT_COUNT; i++) begin
            ref_free.push_back(PR_IDX_W'(ARCH_REGS + i));
        end
        for (int i = 0; i < ARCH_REGS; i++) begin
            ref_map[i] = PR_IDX_W'(i);
        end

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Results of line n are stable one edge later
        for (int n = 0; n < n_lines; n++) begin
            drive_line(n);
            @(posedge clk);
            #1;
            check_line(n);
        end

        rename_en = 1'b0;
        free_en   = 1'b0;
        $display("Regression passed");
        $finish;
    end

endmodule

/* tb/rename_testdata.txt */
// rename_en dest_ar src1_ar src2_ar free_en free_pr
// one line per cycle, every field in hex
0 00 00 00 1 05
1 01 02 03 0 00
1 01 01 04 0 00
1 02 01 01 0 00
0 00 02 01 0 00
1 03 02 00 0 00
1 04 03 05 0 00
1 05 04 06 0 00
1 06 05 07 0 00
1 07 06 08 0 00
1 08 07 09 0 00
1 09 08 0a 0 00
1 0a 09 0b 0 00
1 0b 0a 0c 0 00
1 0c 0b 0d 0 00
1 0d 0c 0e 0 00
1 0e 0d 0f 0 00
1 0f 0e 10 0 00
1 10 0f 10 0 00
0 00 10 0f 0 00
1 11 10 00 1 01
0 00 00 00 1 02
0 00 00 00 1 03
1 12 11 00 1 20
1 13 12 12 0 00
1 14 13 00 0 00
1 15 00 00 0 00
0 00 15 14 0 00
